//--- build.f
design/vecPkg.sv
design/wbMapPkg.sv
design/wbRegs.sv
design/vectorRam.sv
design/vectorGen.sv
design/lineQueue.sv
design/lineRaster.sv
design/vectorDisplay.sv
dv/vectorDisplay_checker.sv
dv/vectorDisplayTb.sv

//--- design/lineQueue.sv
`timescale 1ns/100ps

module lineQueue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              push,
  input  logic [vecPkg::COORD_BITS-1:0]     pushStartX,
  input  logic [vecPkg::COORD_BITS-1:0]     pushStartY,
  input  logic [vecPkg::COORD_BITS-1:0]     pushEndX,
  input  logic [vecPkg::COORD_BITS-1:0]     pushEndY,
  input  logic [vecPkg::INTENSITY_BITS-1:0] pushIntensity,
  input  logic                              pop,
  output logic [vecPkg::COORD_BITS-1:0]     headStartX,
  output logic [vecPkg::COORD_BITS-1:0]     headStartY,
  output logic [vecPkg::COORD_BITS-1:0]     headEndX,
  output logic [vecPkg::COORD_BITS-1:0]     headEndY,
  output logic [vecPkg::INTENSITY_BITS-1:0] headIntensity,
  output logic                              full,
  output logic                              empty
);

  localparam int REC_BITS = 4 * vecPkg::COORD_BITS + vecPkg::INTENSITY_BITS;
  localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST = PTR_BITS'(QUEUE_DEPTH - 1);

  logic [REC_BITS-1:0] mem [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wrPtr;
  logic [PTR_BITS-1:0] rdPtr;
  logic [CNT_BITS-1:0] count;
  logic doPush;
  logic doPop;

  assign doPush = push && !full;
  assign doPop = pop && !empty;

  // Record storage
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= {pushStartX, pushStartY, pushEndX, pushEndY, pushIntensity};
    end
  end

  assign {headStartX, headStartY, headEndX, headEndY, headIntensity} = mem[rdPtr];

  // Pointers wrap at QUEUE_DEPTH
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == LAST) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == LAST) ? '0 : rdPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  assign full = (count == CNT_BITS'(QUEUE_DEPTH));
  assign empty = (count == '0);

endmodule

//--- design/lineRaster.sv
`timescale 1ns/100ps

module lineRaster (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [vecPkg::COORD_BITS-1:0]     headStartX,
  input  logic [vecPkg::COORD_BITS-1:0]     headStartY,
  input  logic [vecPkg::COORD_BITS-1:0]     headEndX,
  input  logic [vecPkg::COORD_BITS-1:0]     headEndY,
  input  logic [vecPkg::INTENSITY_BITS-1:0] headIntensity,
  input  logic                              empty,
  input  logic                              pixelReady,
  output logic                              pop,
  output logic                              pixelValid,
  output logic [vecPkg::COORD_BITS-1:0]     pixelX,
  output logic [vecPkg::COORD_BITS-1:0]     pixelY,
  output logic [vecPkg::INTENSITY_BITS-1:0] pixelIntensity
);

  // Wide enough for twice the error plus sign
  localparam int ERR_BITS = vecPkg::COORD_BITS + 3;

  typedef enum logic {
    IDLE,
    STEP
  } rasterState;

  rasterState state;
  logic [vecPkg::COORD_BITS-1:0] dx;
  logic [vecPkg::COORD_BITS-1:0] dy;
  logic [vecPkg::COORD_BITS-1:0] dMaj;
  logic [vecPkg::COORD_BITS-1:0] dMin;
  logic [vecPkg::COORD_BITS-1:0] remain;
  logic xMajor;
  logic xDec;
  logic yDec;
  logic signed [ERR_BITS-1:0] err;
  logic signed [ERR_BITS-1:0] errNext;
  logic signed [ERR_BITS-1:0] dMajS;
  logic signed [ERR_BITS-1:0] dMinS;
  logic minorStep;
  logic stepX;
  logic stepY;

  //////////////////////////////////////////////////
  // Line setup from the queue head
  //////////////////////////////////////////////////

  assign dx = (headEndX >= headStartX) ? headEndX - headStartX : headStartX - headEndX;
  assign dy = (headEndY >= headStartY) ? headEndY - headStartY : headStartY - headEndY;

  // Take a new line only when idle
  assign pop = (state == IDLE) && !empty;

  //////////////////////////////////////////////////
  // Bresenham step
  //////////////////////////////////////////////////

  assign dMajS = $signed({{(ERR_BITS - vecPkg::COORD_BITS){1'b0}}, dMaj});
  assign dMinS = $signed({{(ERR_BITS - vecPkg::COORD_BITS){1'b0}}, dMin});
  assign errNext = err + dMinS;
  assign minorStep = (errNext + errNext) >= dMajS;

  // Major axis moves every pixel
  assign stepX = xMajor || minorStep;
  assign stepY = !xMajor || minorStep;

  assign pixelValid = (state == STEP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (pop) begin
            state <= STEP;
          end
        end
        default: begin
          // Endpoint transferred
          if (pixelReady && (remain == '0)) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // Datapath loads on pop and advances on each transfer
  always_ff @(posedge clk) begin
    if (pop) begin
      pixelX <= headStartX;
      pixelY <= headStartY;
      pixelIntensity <= headIntensity;
      xMajor <= (dx >= dy);
      dMaj <= (dx >= dy) ? dx : dy;
      dMin <= (dx >= dy) ? dy : dx;
      remain <= (dx >= dy) ? dx : dy;
      xDec <= headEndX < headStartX;
      yDec <= headEndY < headStartY;
      err <= '0;
    end else if (pixelValid && pixelReady && (remain != '0)) begin
      remain <= remain - 1'b1;
      err <= minorStep ? errNext - dMajS : errNext;
      if (stepX) begin
        pixelX <= xDec ? pixelX - 1'b1 : pixelX + 1'b1;
      end
      if (stepY) begin
        pixelY <= yDec ? pixelY - 1'b1 : pixelY + 1'b1;
      end
    end
  end

endmodule

//--- design/vecPkg.sv
package vecPkg;

  //////////////////////////////////////////////////
  // Screen geometry
  //////////////////////////////////////////////////

  // 128 x 128 screen
  localparam int COORD_BITS = 7;

  // Beam brightness where zero turns the beam off
  localparam int INTENSITY_BITS = 4;

  //////////////////////////////////////////////////
  // Instruction word layout
  //////////////////////////////////////////////////

  localparam int INSTR_BITS = 16;

  // Opcode in the top two bits
  localparam int OP_HI = 15;
  localparam int OP_LO = 14;

  // Target coordinate for MOVE and DRAW
  localparam int X_HI = 13;
  localparam int X_LO = 7;
  localparam int Y_HI = 6;
  localparam int Y_LO = 0;

  // SETI takes its value from the low INTENSITY_BITS bits
  typedef enum logic [1:0] {
    MOVE = 2'b00,
    DRAW = 2'b01,
    SETI = 2'b10,
    HALT = 2'b11
  } vecOp;

endpackage

//--- design/vectorDisplay.sv
`timescale 1ns/100ps

module vectorDisplay #(
  parameter int RAM_ADDR_BITS = 8,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  logic [wbMapPkg::ADDR_BITS-1:0]    adr,
  input  logic [vecPkg::INSTR_BITS-1:0]     datW,
  output logic [vecPkg::INSTR_BITS-1:0]     datR,
  output logic                              ack,
  input  logic                              pixelReady,
  output logic                              pixelValid,
  output logic [vecPkg::COORD_BITS-1:0]     pixelX,
  output logic [vecPkg::COORD_BITS-1:0]     pixelY,
  output logic [vecPkg::INTENSITY_BITS-1:0] pixelIntensity
);

  logic ramWe;
  logic [RAM_ADDR_BITS-1:0] ramAddr;
  logic [vecPkg::INSTR_BITS-1:0] ramData;
  logic genGo;
  logic genClr;
  logic halted;
  logic [RAM_ADDR_BITS-1:0] pc;
  logic [vecPkg::INSTR_BITS-1:0] instr;

  // Generator to queue
  logic push;
  logic full;
  logic [vecPkg::COORD_BITS-1:0] startX;
  logic [vecPkg::COORD_BITS-1:0] startY;
  logic [vecPkg::COORD_BITS-1:0] endX;
  logic [vecPkg::COORD_BITS-1:0] endY;
  logic [vecPkg::INTENSITY_BITS-1:0] intensity;

  // Queue to rasterizer
  logic pop;
  logic empty;
  logic [vecPkg::COORD_BITS-1:0] headStartX;
  logic [vecPkg::COORD_BITS-1:0] headStartY;
  logic [vecPkg::COORD_BITS-1:0] headEndX;
  logic [vecPkg::COORD_BITS-1:0] headEndY;
  logic [vecPkg::INTENSITY_BITS-1:0] headIntensity;

  wbRegs #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) regs (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datW(datW), .datR(datR), .ack(ack), .halted(halted), .empty(empty),
    .ramWe(ramWe), .ramAddr(ramAddr), .ramData(ramData),
    .genGo(genGo), .genClr(genClr)
  );

  vectorRam #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) vram (
    .clk(clk), .ramWe(ramWe), .ramAddr(ramAddr), .ramData(ramData),
    .pc(pc), .instr(instr)
  );

  vectorGen #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) gen (
    .clk(clk), .rst(rst), .genGo(genGo), .genClr(genClr), .instr(instr),
    .full(full), .pc(pc), .halted(halted), .push(push),
    .startX(startX), .startY(startY), .endX(endX), .endY(endY),
    .intensity(intensity)
  );

  lineQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue (
    .clk(clk), .rst(rst), .push(push),
    .pushStartX(startX), .pushStartY(startY), .pushEndX(endX), .pushEndY(endY),
    .pushIntensity(intensity), .pop(pop),
    .headStartX(headStartX), .headStartY(headStartY), .headEndX(headEndX),
    .headEndY(headEndY), .headIntensity(headIntensity), .full(full), .empty(empty)
  );

  lineRaster raster (
    .clk(clk), .rst(rst),
    .headStartX(headStartX), .headStartY(headStartY), .headEndX(headEndX),
    .headEndY(headEndY), .headIntensity(headIntensity), .empty(empty),
    .pixelReady(pixelReady), .pop(pop), .pixelValid(pixelValid),
    .pixelX(pixelX), .pixelY(pixelY), .pixelIntensity(pixelIntensity)
  );

endmodule

//--- design/vectorGen.sv
`timescale 1ns/100ps

module vectorGen #(
  parameter int RAM_ADDR_BITS = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              genGo,
  input  logic                              genClr,
  input  logic [vecPkg::INSTR_BITS-1:0]     instr,
  input  logic                              full,
  output logic [RAM_ADDR_BITS-1:0]          pc,
  output logic                              halted,
  output logic                              push,
  output logic [vecPkg::COORD_BITS-1:0]     startX,
  output logic [vecPkg::COORD_BITS-1:0]     startY,
  output logic [vecPkg::COORD_BITS-1:0]     endX,
  output logic [vecPkg::COORD_BITS-1:0]     endY,
  output logic [vecPkg::INTENSITY_BITS-1:0] intensity
);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DECODE,
    WAIT_Q
  } genState;

  genState state;
  vecPkg::vecOp op;
  logic [vecPkg::COORD_BITS-1:0] beamX;
  logic [vecPkg::COORD_BITS-1:0] beamY;
  logic [vecPkg::COORD_BITS-1:0] instrX;
  logic [vecPkg::COORD_BITS-1:0] instrY;
  logic drawVisible;
  logic drawPending;

  // Instruction fields
  assign op = vecPkg::vecOp'(instr[vecPkg::OP_HI:vecPkg::OP_LO]);
  assign instrX = instr[vecPkg::X_HI:vecPkg::X_LO];
  assign instrY = instr[vecPkg::Y_HI:vecPkg::Y_LO];

  // Dark DRAW only moves the beam and never reaches the queue
  assign drawVisible = (op == vecPkg::DRAW) && (intensity != '0);
  assign drawPending = (state == DECODE) || (state == WAIT_Q);

  //////////////////////////////////////////////////
  // Line record toward the queue
  //////////////////////////////////////////////////

  // A clear in the same cycle cancels the record
  assign push = drawPending && drawVisible && !full && !genClr;
  assign startX = beamX;
  assign startY = beamY;
  assign endX = instrX;
  assign endY = instrY;

  //////////////////////////////////////////////////
  // Fetch and decode
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || genClr) begin
      state <= IDLE;
      pc <= '0;
      halted <= 1'b1;
      beamX <= '0;
      beamY <= '0;
      intensity <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (genGo) begin
            pc <= '0;
            halted <= 1'b0;
            state <= FETCH;
          end
        end
        // RAM registers instr during this cycle
        FETCH: state <= DECODE;
        DECODE: begin
          case (op)
            vecPkg::MOVE: begin
              beamX <= instrX;
              beamY <= instrY;
              pc <= pc + 1'b1;
              state <= FETCH;
            end
            vecPkg::DRAW: begin
              if (drawVisible && full) begin
                state <= WAIT_Q;
              end else begin
                beamX <= instrX;
                beamY <= instrY;
                pc <= pc + 1'b1;
                state <= FETCH;
              end
            end
            vecPkg::SETI: begin
              intensity <= instr[vecPkg::INTENSITY_BITS-1:0];
              pc <= pc + 1'b1;
              state <= FETCH;
            end
            default: begin
              halted <= 1'b1;
              state <= IDLE;
            end
          endcase
        end
        // pc is unchanged, so instr still holds the stalled DRAW
        WAIT_Q: begin
          if (!full) begin
            beamX <= instrX;
            beamY <= instrY;
            pc <= pc + 1'b1;
            state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- design/vectorRam.sv
`timescale 1ns/100ps

module vectorRam #(
  parameter int RAM_ADDR_BITS = 8
) (
  input  logic                          clk,
  input  logic                          ramWe,
  input  logic [RAM_ADDR_BITS-1:0]      ramAddr,
  input  logic [vecPkg::INSTR_BITS-1:0] ramData,
  input  logic [RAM_ADDR_BITS-1:0]      pc,
  output logic [vecPkg::INSTR_BITS-1:0] instr
);

  logic [vecPkg::INSTR_BITS-1:0] mem [2**RAM_ADDR_BITS];

  // Write-only host port
  always_ff @(posedge clk) begin
    if (ramWe) begin
      mem[ramAddr] <= ramData;
    end
  end

  // Generator port with one cycle of read latency
  always_ff @(posedge clk) begin
    instr <= mem[pc];
  end

endmodule

//--- design/wbMapPkg.sv
package wbMapPkg;

  // Word address width of the host bus
  localparam int ADDR_BITS = 9;

  // Everything below CTRL_ADDR is the vector RAM window
  localparam logic [ADDR_BITS-1:0] CTRL_ADDR = 9'h100;
  localparam logic [ADDR_BITS-1:0] STATUS_ADDR = 9'h101;

  // Write-only control register bits
  localparam int GO_BIT = 0;
  localparam int CLR_BIT = 1;

  // Read-only status register bits
  localparam int HALT_BIT = 0;
  localparam int EMPTY_BIT = 1;

endpackage

//--- design/wbRegs.sv
`timescale 1ns/100ps

module wbRegs #(
  parameter int RAM_ADDR_BITS = 8
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cyc,
  input  logic                              stb,
  input  logic                              we,
  input  logic [wbMapPkg::ADDR_BITS-1:0]    adr,
  input  logic [vecPkg::INSTR_BITS-1:0]     datW,
  output logic [vecPkg::INSTR_BITS-1:0]     datR,
  output logic                              ack,
  input  logic                              halted,
  input  logic                              empty,
  output logic                              ramWe,
  output logic [RAM_ADDR_BITS-1:0]          ramAddr,
  output logic [vecPkg::INSTR_BITS-1:0]     ramData,
  output logic                              genGo,
  output logic                              genClr
);

  logic req;
  logic inRam;
  logic ctrlWr;

  // New request only while ack is low, so each access is served once
  assign req = cyc && stb && !ack;
  assign inRam = adr < wbMapPkg::CTRL_ADDR;
  assign ctrlWr = req && we && (adr == wbMapPkg::CTRL_ADDR);

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // RAM write lands on the same edge that raises ack
  assign ramWe = req && we && inRam;
  assign ramAddr = adr[RAM_ADDR_BITS-1:0];
  assign ramData = datW;

  // Control bits act as single-cycle strobes
  assign genGo = ctrlWr && datW[wbMapPkg::GO_BIT];
  assign genClr = ctrlWr && datW[wbMapPkg::CLR_BIT];

  //////////////////////////////////////////////////
  // Handshake and read side
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  // RAM window reads back as zero
  always_ff @(posedge clk) begin
    if (req && !we) begin
      datR <= '0;
      if (adr == wbMapPkg::STATUS_ADDR) begin
        datR[wbMapPkg::HALT_BIT] <= halted;
        datR[wbMapPkg::EMPTY_BIT] <= empty;
      end
    end
  end

endmodule

//--- dv/vectorDisplayTb.sv
`timescale 1ns/100ps

module vectorDisplayTb;

  localparam int REC_MAX = 256;
  localparam int CYCLES_PER_REC = 300;

  logic clk = 1'b0;
  logic rst;
  logic cyc;
  logic stb;
  logic we;
  logic [wbMapPkg::ADDR_BITS-1:0] adr;
  logic [vecPkg::INSTR_BITS-1:0] datW;
  logic [vecPkg::INSTR_BITS-1:0] datR;
  logic ack;
  logic pixelReady = 1'b0;
  logic pixelValid;
  logic [vecPkg::COORD_BITS-1:0] pixelX;
  logic [vecPkg::COORD_BITS-1:0] pixelY;
  logic [vecPkg::INTENSITY_BITS-1:0] pixelIntensity;

  // Record holds tag[39:36] field1[35:24] field2[23:8] and field3[7:0]
  logic [39:0] patterns [REC_MAX];
  logic [39:0] pixQ [$];
  logic [39:0] rec;
  logic [39:0] expPix;
  logic [15:0] rdata;
  int recCount;
  int pixCount = 0;
  int pixBefore = 0;
  bit loaded = 1'b0;
  integer seed = 74;

  vectorDisplay #(
    .RAM_ADDR_BITS(8),
    .QUEUE_DEPTH(4)
  ) uut (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datW(datW), .datR(datR), .ack(ack), .pixelReady(pixelReady),
    .pixelValid(pixelValid), .pixelX(pixelX), .pixelY(pixelY),
    .pixelIntensity(pixelIntensity)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////

  task automatic abortRun();
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic checkEqual(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abortRun();
    end
  endtask

  //////////////////////////////////////////////////
  // Host bus master
  //////////////////////////////////////////////////

  task automatic busCycle(input logic write, input logic [wbMapPkg::ADDR_BITS-1:0] addr,
                          input logic [15:0] wdata, output logic [15:0] data);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = addr;
    datW = wdata;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
    data = datR;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  // Frame ends with generator halted, queue empty and no pixel pending
  task automatic waitFrameEnd();
    logic [15:0] status;
    logic done;
    done = 1'b0;
    while (!done) begin
      busCycle(1'b0, wbMapPkg::STATUS_ADDR, 16'h0000, status);
      done = status[wbMapPkg::HALT_BIT] && status[wbMapPkg::EMPTY_BIT] && !pixelValid;
    end
  endtask

  //////////////////////////////////////////////////
  // Pixel sink
  //////////////////////////////////////////////////

  // Roughly one cycle in three stalls the rasterizer
  always @(posedge clk) begin
    #1;
    pixelReady = ({$random(seed)} % 3) != 0;
  end

  // Sample mid-cycle before the edge that transfers the pixel
  always @(negedge clk) begin
    if (!rst && pixelValid && pixelReady) begin
      if (pixCount >= pixQ.size()) begin
        $display("Pixel at %0d,%0d arrived past the end of the expected list",
                 pixelX, pixelY);
        abortRun();
      end else begin
        expPix = pixQ[pixCount];
        checkEqual("pixelX", 32'(pixelX), 32'(expPix[35:24]));
        checkEqual("pixelY", 32'(pixelY), 32'(expPix[23:8]));
        checkEqual("pixelIntensity", 32'(pixelIntensity), 32'(expPix[7:0]));
        pixCount = pixCount + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Record sequencer
  //////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datW = '0;
    for (int i = 0; i < REC_MAX; i++) begin
      patterns[i] = '0;
    end
    $readmemh("dv/vectorPatterns.hex", patterns);
    // Tag zero marks the end of the list
    recCount = 0;
    while (recCount < REC_MAX && patterns[recCount][39:36] != 4'h0) begin
      if (patterns[recCount][39:36] == 4'h3) begin
        pixQ.push_back(patterns[recCount]);
      end
      recCount = recCount + 1;
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < recCount; i++) begin
      rec = patterns[i];
      case (rec[39:36])
        4'h1: busCycle(1'b1, rec[32:24], rec[23:8], rdata);
        4'h2: begin
          busCycle(1'b0, rec[32:24], 16'h0000, rdata);
          checkEqual("datR", 32'(rdata), 32'(rec[23:8]));
        end
        4'h3: pixBefore = pixBefore + 1;
        4'h4: begin
          waitFrameEnd();
          checkEqual("pixelCount", 32'(pixCount), 32'(pixBefore));
        end
        default: begin
          $display("Record %0d in the pattern file has an unknown tag", i);
          abortRun();
        end
      endcase
    end
    checkEqual("pixelCount", 32'(pixCount), 32'(pixQ.size()));
    $display("=== PASS ===");
    $finish;
  end

  // Budget scales with the number of records
  initial begin
    wait (loaded);
    repeat ((recCount + 1) * CYCLES_PER_REC) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not finish",
             (recCount + 1) * CYCLES_PER_REC);
    abortRun();
  end

endmodule

//--- dv/vectorDisplay_checker.sv
`timescale 1ns/100ps

module vectorDisplay_checker (
  input logic                              clk,
  input logic                              rst,
  input logic                              ack,
  input logic                              push,
  input logic                              full,
  input logic                              pixelValid,
  input logic                              pixelReady,
  input logic [vecPkg::COORD_BITS-1:0]     pixelX,
  input logic [vecPkg::COORD_BITS-1:0]     pixelY,
  input logic [vecPkg::INTENSITY_BITS-1:0] pixelIntensity
);

  // Classic slave gives one ack beat per request
  ackSingleBeat: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ack high on two consecutive cycles");

  // Stalled pixel holds until it transfers
  pixelHeld: assert property (@(posedge clk) disable iff (rst)
    (pixelValid && !pixelReady) |=> (pixelValid && $stable(pixelX) && $stable(pixelY)
      && $stable(pixelIntensity)))
    else $error("pixel changed or dropped while stalled");

  noPushWhenFull: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("line record pushed into a full queue");

endmodule

bind vectorDisplay vectorDisplay_checker chk (
  .clk(clk), .rst(rst), .ack(ack), .push(push), .full(full),
  .pixelValid(pixelValid), .pixelReady(pixelReady),
  .pixelX(pixelX), .pixelY(pixelY), .pixelIntensity(pixelIntensity)
);

//--- dv/vectorPatterns.hex
// Columns: tag(1) field1(3) field2(4) field3(2)
// tag 1 write adr,data / 2 read adr,value / 3 pixel x,y,intensity / 4 wait frame end
// Status after reset, RAM window reads zero
2101000300 2005000000
// MOVE 2,3 SETI 9 DRAW 6,5 HALT
1000010300 1001800900 1002430500 1003C00000 1100000100
3002000309 3003000409 3004000409 3005000509 3006000509
4000000000
// Dark DRAW to 10,10 then a visible line from there
1000800000 1001450A00 1002800500 1003450C00 1004C00000 1100000100
300A000A05 300A000B05 300A000C05
4000000000
// Seven lines in all directions, more than the queue holds
10000A1400 1001800700 10024B9600 10034A9900 1004491800
1005499500 1006481500 1007481300 1008481300 1009C00000 1100000100
3014001407 3015001507 3016001507 3017001607
3017001607 3016001707 3016001807 3015001907
3015001907 3014001907 3013001807 3012001807
3012001807 3012001707 3013001607 3013001507
3013001507 3012001507 3011001507 3010001507
3010001507 3010001407 3010001307 3010001307
4000000000 2101000300
// Clear right after go, then restart from pc 0
1100000100 1100000200 2101000300 1100000100
3014001407 3015001507 3016001507 3017001607
3017001607 3016001707 3016001807 3015001907
3015001907 3014001907 3013001807 3012001807
3012001807 3012001707 3013001607 3013001507
3013001507 3012001507 3011001507 3010001507
3010001507 3010001407 3010001307 3010001307
4000000000 2101000300

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/100ps -f build.f \
    --top-module vectorDisplayTb -o vectorDisplaySim &&
  ./obj_dir/vectorDisplaySim ||
  { echo "simulation failed"; exit 1; }
